// ==== hw/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Data path and bus address width
`define MIPS_XLEN 32

// General purpose register count
`define MIPS_NREGS 32

// First instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Register v0, shown on register_v0
`define MIPS_REG_V0 2

`endif

// ==== hw/mips_pkg.sv ====
package mips_pkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_R     = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // Function field of R-type words, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [1:0] {
        PH_FETCH  = 2'd0,
        PH_EXEC   = 2'd1,
        PH_MEM    = 2'd2,
        PH_HALTED = 2'd3
    } phase_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // One instruction word, J index is the low 26 bits of either view
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

endpackage

// ==== hw/mips_regfile.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [4:0]           rs_addr,
    input  logic [4:0]           rt_addr,
    input  logic                 wr_en,
    input  logic [4:0]           wr_addr,
    input  logic [`MIPS_XLEN-1:0] wr_data,
    output logic [`MIPS_XLEN-1:0] rs_data,
    output logic [`MIPS_XLEN-1:0] rt_data,
    output logic [`MIPS_XLEN-1:0] v0
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    // Register zero is never written, so it stays at its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational read ports
    always_comb begin
        rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
        rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];
    end

    assign v0 = regs[`MIPS_REG_V0];

endmodule

// ==== hw/mips_alu.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_alu (
    input  mips_pkg::instr_t      instr,
    input  logic [`MIPS_XLEN-1:0] rs_data,
    input  logic [`MIPS_XLEN-1:0] rt_data,
    output logic [`MIPS_XLEN-1:0] result,
    output logic [4:0]            dest,
    output logic                  writes_reg
);

    logic [`MIPS_XLEN-1:0] imm_sext;
    logic [`MIPS_XLEN-1:0] imm_zext;
    logic                  is_alu_op;

    assign imm_sext = {{(`MIPS_XLEN-16){instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, instr.i.imm};

    // Opcodes that may write a result register
    assign is_alu_op = instr.i.opcode inside {mips_pkg::OP_R, mips_pkg::OP_ADDIU,
                                              mips_pkg::OP_SLTI, mips_pkg::OP_ANDI,
                                              mips_pkg::OP_ORI, mips_pkg::OP_XORI,
                                              mips_pkg::OP_LUI};

    always_comb begin
        result     = '0;
        dest       = instr.i.rt;
        writes_reg = 1'b1;
        case (instr.i.opcode)
            mips_pkg::OP_R: begin
                dest = instr.r.rd;
                case (instr.r.funct)
                    mips_pkg::FN_SLL:  result = rt_data << instr.r.shamt;
                    mips_pkg::FN_SRL:  result = rt_data >> instr.r.shamt;
                    mips_pkg::FN_SRA:  result = $signed(rt_data) >>> instr.r.shamt;
                    mips_pkg::FN_ADDU: result = rs_data + rt_data;
                    mips_pkg::FN_SUBU: result = rs_data - rt_data;
                    mips_pkg::FN_AND:  result = rs_data & rt_data;
                    mips_pkg::FN_OR:   result = rs_data | rt_data;
                    mips_pkg::FN_XOR:  result = rs_data ^ rt_data;
                    mips_pkg::FN_SLT:  result = `MIPS_XLEN'($signed(rs_data) < $signed(rt_data));
                    mips_pkg::FN_SLTU: result = `MIPS_XLEN'(rs_data < rt_data);
                    // JR and unknown functions leave the registers alone
                    default:           writes_reg = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: result = rs_data + imm_sext;
            mips_pkg::OP_SLTI:  result = `MIPS_XLEN'($signed(rs_data) < $signed(imm_sext));
            mips_pkg::OP_ANDI:  result = rs_data & imm_zext;
            mips_pkg::OP_ORI:   result = rs_data | imm_zext;
            mips_pkg::OP_XORI:  result = rs_data ^ imm_zext;
            mips_pkg::OP_LUI:   result = {instr.i.imm, {(`MIPS_XLEN-16){1'b0}}};
            // Branches, jumps, loads, stores and unknown words
            default:            writes_reg = 1'b0;
        endcase
    end

    // A register write must come from a decoded ALU-class opcode
    always_comb begin
        if (writes_reg) begin
            assert (is_alu_op)
                else $error("ALU write for non-ALU opcode %h", instr.i.opcode);
        end
    end

endmodule

// ==== hw/mips_pc_unit.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_pc_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  retire,
    input  mips_pkg::instr_t      instr,
    input  logic [`MIPS_XLEN-1:0] rs_data,
    input  logic [`MIPS_XLEN-1:0] rt_data,
    output logic [`MIPS_XLEN-1:0] pc
);

    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] jump_target;
    logic [`MIPS_XLEN-1:0] next_target;
    logic [`MIPS_XLEN-1:0] target_q;
    logic                  pending;
    logic                  is_jr;
    logic                  is_flow;
    logic                  taken;

    assign pc_plus4      = pc + `MIPS_XLEN'(4);
    assign branch_target = pc_plus4 + {{(`MIPS_XLEN-18){instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign jump_target   = {pc_plus4[`MIPS_XLEN-1:28], instr[25:0], 2'b00};

    assign is_jr   = (instr.r.opcode == mips_pkg::OP_R) && (instr.r.funct == mips_pkg::FN_JR);
    assign is_flow = is_jr || (instr.i.opcode inside {mips_pkg::OP_BEQ, mips_pkg::OP_BNE,
                                                      mips_pkg::OP_J});

    // Branch decision from the register operands
    always_comb begin
        taken       = 1'b0;
        next_target = branch_target;
        case (instr.i.opcode)
            mips_pkg::OP_BEQ: taken = (rs_data == rt_data);
            mips_pkg::OP_BNE: taken = (rs_data != rt_data);
            mips_pkg::OP_J: begin
                taken       = 1'b1;
                next_target = jump_target;
            end
            default: begin
                taken       = is_jr;
                next_target = rs_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `MIPS_RESET_VECTOR;
            pending <= 1'b0;
        end else if (retire) begin
            // Delay slot done, redirect now
            if (pending) begin
                pc      <= target_q;
                pending <= 1'b0;
            end else begin
                pc      <= pc_plus4;
                pending <= taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire && !pending && taken) begin
            target_q <= next_target;
        end
    end

    // Branches in a delay slot are not supported
    assert property (@(posedge clk) disable iff (reset) (retire && pending) |-> !is_flow)
        else $error("branch or jump retired in a delay slot at pc %h", pc);

endmodule

// ==== hw/mips_control.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_control (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`MIPS_XLEN-1:0]     pc,
    input  logic                      waitrequest,
    input  logic [`MIPS_XLEN-1:0]     readdata,
    input  logic [`MIPS_XLEN-1:0]     rs_data,
    input  logic [`MIPS_XLEN-1:0]     rt_data,
    input  logic [`MIPS_XLEN-1:0]     alu_result,
    input  logic [4:0]                alu_dest,
    input  logic                      alu_writes_reg,
    output logic                      active,
    output mips_pkg::instr_t          instr,
    output logic [4:0]                rs_addr,
    output logic [4:0]                rt_addr,
    output logic                      retire,
    output logic                      rf_wr_en,
    output logic [4:0]                rf_wr_addr,
    output logic [`MIPS_XLEN-1:0]     rf_wr_data,
    output logic [`MIPS_XLEN-1:0]     address,
    output logic                      read,
    output logic                      write,
    output logic [`MIPS_XLEN-1:0]     writedata,
    output logic [`MIPS_XLEN/8-1:0]   byteenable
);

    mips_pkg::phase_t      phase;
    logic                  is_lw;
    logic                  is_sw;
    logic                  halt_now;
    logic [`MIPS_XLEN-1:0] mem_addr;

    assign is_lw    = (instr.i.opcode == mips_pkg::OP_LW);
    assign is_sw    = (instr.i.opcode == mips_pkg::OP_SW);
    assign halt_now = (phase == mips_pkg::PH_FETCH) && (pc == '0);
    assign mem_addr = rs_data + {{(`MIPS_XLEN-16){instr.i.imm[15]}}, instr.i.imm};

    assign rs_addr = instr.r.rs;
    assign rt_addr = instr.r.rt;
    assign active  = (phase != mips_pkg::PH_HALTED);

    // Phase sequencing, every transfer holds until waitrequest drops
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= mips_pkg::PH_FETCH;
        end else begin
            case (phase)
                mips_pkg::PH_FETCH: begin
                    if (halt_now) begin
                        phase <= mips_pkg::PH_HALTED;
                    end else if (!waitrequest) begin
                        phase <= mips_pkg::PH_EXEC;
                    end
                end
                mips_pkg::PH_EXEC: begin
                    phase <= (is_lw || is_sw) ? mips_pkg::PH_MEM : mips_pkg::PH_FETCH;
                end
                mips_pkg::PH_MEM: begin
                    if (!waitrequest) begin
                        phase <= mips_pkg::PH_FETCH;
                    end
                end
                default: phase <= mips_pkg::PH_HALTED;
            endcase
        end
    end

    // Instruction register, loaded as the fetch completes
    always_ff @(posedge clk) begin
        if ((phase == mips_pkg::PH_FETCH) && !halt_now && !waitrequest) begin
            instr <= readdata;
        end
    end

    // Bus master outputs
    always_comb begin
        read    = 1'b0;
        write   = 1'b0;
        address = pc;
        if ((phase == mips_pkg::PH_FETCH) && !halt_now) begin
            read = 1'b1;
        end else if (phase == mips_pkg::PH_MEM) begin
            read    = is_lw;
            write   = is_sw;
            address = mem_addr;
        end
    end

    assign writedata  = rt_data;
    assign byteenable = '1;

    // Retire and register write back
    always_comb begin
        retire     = 1'b0;
        rf_wr_en   = 1'b0;
        rf_wr_addr = alu_dest;
        rf_wr_data = alu_result;
        if ((phase == mips_pkg::PH_EXEC) && !is_lw && !is_sw) begin
            retire   = 1'b1;
            rf_wr_en = alu_writes_reg;
        end else if ((phase == mips_pkg::PH_MEM) && !waitrequest) begin
            retire     = 1'b1;
            rf_wr_en   = is_lw;
            rf_wr_addr = instr.i.rt;
            rf_wr_data = readdata;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write asserted together");

    // A stalled transfer keeps its address and strobes
    assert property (@(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=> ($stable(address) && $stable(read) && $stable(write)))
        else $error("bus request changed under waitrequest");

endmodule

// ==== hw/mips_cpu_bus.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_cpu_bus (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    active,
    output logic [`MIPS_XLEN-1:0]   register_v0,
    output logic [`MIPS_XLEN-1:0]   address,
    output logic                    write,
    output logic                    read,
    input  logic                    waitrequest,
    output logic [`MIPS_XLEN-1:0]   writedata,
    output logic [`MIPS_XLEN/8-1:0] byteenable,
    input  logic [`MIPS_XLEN-1:0]   readdata
);

    mips_pkg::instr_t      instr;
    logic [`MIPS_XLEN-1:0] pc;
    logic [4:0]            rs_addr;
    logic [4:0]            rt_addr;
    logic [`MIPS_XLEN-1:0] rs_data;
    logic [`MIPS_XLEN-1:0] rt_data;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic [4:0]            alu_dest;
    logic                  alu_writes_reg;
    logic                  retire;
    logic                  rf_wr_en;
    logic [4:0]            rf_wr_addr;
    logic [`MIPS_XLEN-1:0] rf_wr_data;

    mips_regfile u_regfile (
        .clk(clk), .reset(reset),
        .rs_addr(rs_addr), .rt_addr(rt_addr),
        .wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data),
        .rs_data(rs_data), .rt_data(rt_data), .v0(register_v0)
    );

    mips_alu u_alu (
        .instr(instr), .rs_data(rs_data), .rt_data(rt_data),
        .result(alu_result), .dest(alu_dest), .writes_reg(alu_writes_reg)
    );

    mips_pc_unit u_pc_unit (
        .clk(clk), .reset(reset), .retire(retire),
        .instr(instr), .rs_data(rs_data), .rt_data(rt_data),
        .pc(pc)
    );

    mips_control u_control (
        .clk(clk), .reset(reset), .pc(pc),
        .waitrequest(waitrequest), .readdata(readdata),
        .rs_data(rs_data), .rt_data(rt_data),
        .alu_result(alu_result), .alu_dest(alu_dest), .alu_writes_reg(alu_writes_reg),
        .active(active), .instr(instr),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .retire(retire),
        .rf_wr_en(rf_wr_en), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data),
        .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable)
    );

endmodule

// ==== sim/avalon_mem_model.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module avalon_mem_model (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wait_enable,
    input  logic [`MIPS_XLEN-1:0]   address,
    input  logic                    read,
    input  logic                    write,
    input  logic [`MIPS_XLEN-1:0]   writedata,
    input  logic [`MIPS_XLEN/8-1:0] byteenable,
    output logic [`MIPS_XLEN-1:0]   readdata,
    output logic                    waitrequest,
    output logic                    bus_fault
);

    localparam logic [31:0] LFSR_SEED = 32'h5852_ced7;

    // 64 program words at the reset vector, 64 data words from address zero
    logic [`MIPS_XLEN-1:0] prog_mem [64];
    logic [`MIPS_XLEN-1:0] data_mem [64];
    logic [31:0]           lfsr;
    logic                  in_prog;
    logic                  in_data;
    logic                  stall_q;
    logic [`MIPS_XLEN-1:0] addr_q;
    logic                  read_q;
    logic                  write_q;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign in_prog  = (address[31:8] == 24'(`MIPS_RESET_VECTOR >> 8));
    assign in_data  = (address[31:8] == 24'h0);
    assign readdata = in_prog ? prog_mem[address[7:2]] :
                      (in_data ? data_mem[address[7:2]] : '0);

    // One LFSR bit per request cycle decides the stall
    assign waitrequest = wait_enable && (read || write) && lfsr[0];

    always @(posedge clk) begin
        if (reset) begin
            lfsr      <= LFSR_SEED;
            stall_q   <= 1'b0;
            bus_fault <= 1'b0;
        end else begin
            if (wait_enable && (read || write)) begin
                lfsr <= lfsr_step(lfsr);
            end
            if (write && !waitrequest && in_data) begin
                data_mem[address[7:2]] <= writedata;
            end
            if (read || write) begin
                assert (byteenable === '1) else begin
                    $display("FAILED byteenable expected %h actual %h", 4'hf, byteenable);
                    bus_fault <= 1'b1;
                end
                assert (in_prog || in_data) else begin
                    $display("Bus access outside the mapped memory at address %h", address);
                    bus_fault <= 1'b1;
                end
            end
            // Stalled request must come back unchanged
            if (stall_q) begin
                assert ((address === addr_q) && (read === read_q) && (write === write_q))
                    else begin
                    $display("FAILED address %h -> %h read %h -> %h write %h -> %h",
                             addr_q, address, read_q, read, write_q, write);
                    bus_fault <= 1'b1;
                end
            end
            stall_q <= (read || write) && waitrequest;
            addr_q  <= address;
            read_q  <= read;
            write_q <= write;
        end
    end

endmodule

// ==== sim/tb_mips_cpu_bus.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module tb_mips_cpu_bus;

    // Executed instructions over all six runs
    localparam int TOTAL_INSTR = 67;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 3 * 8 + 6 * 8;

    logic                    clk;
    logic                    reset;
    logic                    wait_enable;
    logic                    active;
    logic [`MIPS_XLEN-1:0]   register_v0;
    logic [`MIPS_XLEN-1:0]   address;
    logic                    write;
    logic                    read;
    logic                    waitrequest;
    logic [`MIPS_XLEN-1:0]   writedata;
    logic [`MIPS_XLEN/8-1:0] byteenable;
    logic [`MIPS_XLEN-1:0]   readdata;
    logic                    bus_fault;
    logic [31:0]             prog_q [$];

    mips_cpu_bus uut (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    avalon_mem_model mem (
        .clk(clk), .reset(reset), .wait_enable(wait_enable),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest),
        .bus_fault(bus_fault)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("Timeout, the CPU did not halt within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    always @(posedge clk) begin
        if (!reset) begin
            assert (!bus_fault) else begin
                $display("RESULT: FAIL");
                $fatal(1, "bus check failed");
            end
        end
    end

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh,
                                           input mips_pkg::funct_t fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(input mips_pkg::opcode_t op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(input logic [25:0] index);
        return {mips_pkg::OP_J, index};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // JR to address zero with a NOP in its delay slot
    task automatic append_halt();
        prog_q.push_back(r_word(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::FN_JR));
        prog_q.push_back(32'h0);
    endtask

    task automatic run_program(input logic waits);
        logic [31:0] a;
        @(posedge clk);
        #1;
        reset = 1'b1;
        wait_enable = waits;
        for (int i = 0; i < 64; i++) begin
            a = `MIPS_RESET_VECTOR + 32'(i * 4);
            // Unused program words overwrite v0, so a stray fetch shows up
            mem.prog_mem[i] = (i < prog_q.size()) ? prog_q[i] :
                              i_word(mips_pkg::OP_LUI, 5'd0, 5'd2, a[31:16] ^ a[15:0]);
            mem.data_mem[i] = 32'hd47a_0000 ^ 32'(i * 4);
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("read", 32'd1, 32'(read));
        check_value("address", `MIPS_RESET_VECTOR, address);
        check_value("write", 32'd0, 32'(write));
        check_value("active", 32'd1, 32'(active));
        while (active === 1'b1) begin
            @(posedge clk);
            #1;
        end
        check_value("active", 32'd0, 32'(active));
        check_value("read", 32'd0, 32'(read));
        check_value("write", 32'd0, 32'(write));
        prog_q.delete();
    endtask

    task automatic reset_and_halt();
        append_halt();
        run_program(1'b0);
        check_value("register_v0", 32'h0, register_v0);
    endtask

    task automatic reg_alu_ops();
        mips_pkg::funct_t ops [10];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] expected;
        logic [4:0]  sh;
        a = 32'h8765_4321;
        b = 32'h1234_fedc;
        sh = 5'd5;
        expected = 32'h0;
        ops = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
                mips_pkg::FN_XOR, mips_pkg::FN_SLT, mips_pkg::FN_SLTU, mips_pkg::FN_SLL,
                mips_pkg::FN_SRL, mips_pkg::FN_SRA};
        prog_q.push_back(i_word(mips_pkg::OP_LUI, 5'd0, 5'd8, a[31:16]));
        prog_q.push_back(i_word(mips_pkg::OP_ORI, 5'd8, 5'd8, a[15:0]));
        prog_q.push_back(i_word(mips_pkg::OP_LUI, 5'd0, 5'd9, b[31:16]));
        prog_q.push_back(i_word(mips_pkg::OP_ORI, 5'd9, 5'd9, b[15:0]));
        for (int k = 0; k < 10; k++) begin
            case (ops[k])
                mips_pkg::FN_ADDU: r = a + b;
                mips_pkg::FN_SUBU: r = a - b;
                mips_pkg::FN_AND:  r = a & b;
                mips_pkg::FN_OR:   r = a | b;
                mips_pkg::FN_XOR:  r = a ^ b;
                mips_pkg::FN_SLT:  r = {31'b0, $signed(a) < $signed(b)};
                mips_pkg::FN_SLTU: r = {31'b0, a < b};
                mips_pkg::FN_SLL:  r = a << sh;
                mips_pkg::FN_SRL:  r = a >> sh;
                default:           r = $signed(a) >>> sh;
            endcase
            // Shifts take the negative operand from rt
            if (k >= 7) begin
                prog_q.push_back(r_word(5'd0, 5'd8, 5'd10, sh, ops[k]));
            end else begin
                prog_q.push_back(r_word(5'd8, 5'd9, 5'd10, 5'd0, ops[k]));
            end
            prog_q.push_back(r_word(5'd2, 5'd10, 5'd2, 5'd0, mips_pkg::FN_ADDU));
            expected = expected + r;
        end
        append_halt();
        run_program(1'b0);
        check_value("register_v0", expected, register_v0);
    endtask

    task automatic imm_ops();
        logic [31:0] c;
        logic [31:0] expected;
        c = 32'hf0f0_8421;
        prog_q.push_back(i_word(mips_pkg::OP_LUI, 5'd0, 5'd8, c[31:16]));
        prog_q.push_back(i_word(mips_pkg::OP_ORI, 5'd8, 5'd8, c[15:0]));
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd8, 5'd2, 16'hfffd));
        prog_q.push_back(i_word(mips_pkg::OP_SLTI, 5'd8, 5'd10, 16'h0005));
        prog_q.push_back(r_word(5'd2, 5'd10, 5'd2, 5'd0, mips_pkg::FN_ADDU));
        prog_q.push_back(i_word(mips_pkg::OP_ANDI, 5'd8, 5'd10, 16'h8001));
        prog_q.push_back(r_word(5'd2, 5'd10, 5'd2, 5'd0, mips_pkg::FN_ADDU));
        prog_q.push_back(i_word(mips_pkg::OP_XORI, 5'd8, 5'd10, 16'h8000));
        prog_q.push_back(r_word(5'd2, 5'd10, 5'd2, 5'd0, mips_pkg::FN_ADDU));
        append_halt();
        // ADDIU and SLTI sign-extend, ANDI and XORI zero-extend
        expected = c + 32'hffff_fffd;
        expected = expected + {31'b0, $signed(c) < 32'sd5};
        expected = expected + (c & 32'h0000_8001);
        expected = expected + (c ^ 32'h0000_8000);
        run_program(1'b0);
        check_value("register_v0", expected, register_v0);
    endtask

    task automatic load_store(input logic waits);
        logic [31:0] word;
        word = 32'ha5c3_1e77 + 32'h40;
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd0, 5'd8, 16'h0040));
        prog_q.push_back(i_word(mips_pkg::OP_LUI, 5'd0, 5'd9, 16'ha5c3));
        prog_q.push_back(i_word(mips_pkg::OP_ORI, 5'd9, 5'd9, 16'h1e77));
        prog_q.push_back(r_word(5'd9, 5'd8, 5'd9, 5'd0, mips_pkg::FN_ADDU));
        prog_q.push_back(i_word(mips_pkg::OP_SW, 5'd8, 5'd9, 16'h0008));
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd8, 5'd10, 16'h0010));
        // Load back from 0x50 - 8 through a negative offset
        prog_q.push_back(i_word(mips_pkg::OP_LW, 5'd10, 5'd2, 16'hfff8));
        append_halt();
        run_program(waits);
        check_value("register_v0", word, register_v0);
        check_value("data_mem[0x48]", word, mem.data_mem[18]);
    endtask

    task automatic branch_delay_slots();
        logic [31:0] jt;
        jt = (`MIPS_RESET_VECTOR + 32'd40) >> 2;
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd0, 5'd8, 16'd7));
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd0, 5'd9, 16'd7));
        prog_q.push_back(i_word(mips_pkg::OP_BEQ, 5'd8, 5'd9, 16'd2));
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0100));
        prog_q.push_back(i_word(mips_pkg::OP_BNE, 5'd8, 5'd9, 16'd2));
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0010));
        prog_q.push_back(j_word(jt[25:0]));
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0020));
        prog_q.push_back(i_word(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0400));
        append_halt();
        run_program(1'b0);
        // Words 3, 6 and 8 run; the BEQ skips word 4 and the J skips word 9
        check_value("register_v0", 32'h1 + 32'h10 + 32'h20, register_v0);
    endtask

    initial begin
        reset = 1'b1;
        wait_enable = 1'b0;
        reset_and_halt();
        reg_alu_ops();
        imm_ops();
        load_store(1'b0);
        branch_delay_slots();
        load_store(1'b1);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/mips_pkg.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_pc_unit.sv
hw/mips_control.sv
hw/mips_cpu_bus.sv
sim/avalon_mem_model.sv
sim/tb_mips_cpu_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_mips_cpu_bus \
    -f tb.f -o tb_mips_cpu_bus_sim

./obj_dir/tb_mips_cpu_bus_sim | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
